// File: rv_decode_settings.svh
// --------------------
// Widths for the RV32I decode stage
// The format views in the package assume a 32-bit instruction
// and 5-bit register addresses
// --------------------
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// Register and PC width
`define RV_XLEN         32

`define RV_INSTR_W      32      // No compressed encodings
`define RV_REG_ADDR_W   5

// Step from PC to next PC
`define RV_ILEN_BYTES   4

`endif

// File: rv_decode_pkg.sv
// --------------------
// Types shared by the decode stage and its submodules
// All ZERO / NONE / NOP encodings are 0, so an all-zero control word is a NOP
// --------------------
`include "rv_decode_settings.svh"

package rv_decode_pkg;

    typedef logic [`RV_XLEN-1:0]       xlen_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // Instruction formats
    // --------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One word, six ways of reading it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // Operation codes
    // --------------------
    typedef enum logic [3:0] {
        ALU_OP_NOP, ALU_OP_ADD, ALU_OP_SUB, ALU_OP_SLL, ALU_OP_SLT, ALU_OP_SLTU,
        ALU_OP_XOR, ALU_OP_SRL, ALU_OP_SRA, ALU_OP_OR, ALU_OP_AND
    } alu_op_t;

    typedef enum logic [3:0] {
        LSU_OP_NONE, LSU_OP_LB, LSU_OP_LBU, LSU_OP_LH, LSU_OP_LHU,
        LSU_OP_LW, LSU_OP_SB, LSU_OP_SH, LSU_OP_SW
    } lsu_op_t;

    typedef enum logic [2:0] {
        CFU_OP_NONE, CFU_OP_BEQ, CFU_OP_BNE, CFU_OP_BLT,
        CFU_OP_BGE, CFU_OP_BLTU, CFU_OP_BGEU, CFU_OP_JAL
    } cfu_op_t;

    typedef enum logic [1:0] {OPR_A_ZERO, OPR_A_RS1, OPR_A_PC} opr_a_sel_t;
    typedef enum logic [1:0] {OPR_B_ZERO, OPR_B_RS2, OPR_B_IMM} opr_b_sel_t;

    typedef enum logic [2:0] {
        OPR_C_ZERO, OPR_C_RS2, OPR_C_IMM_B, OPR_C_IMM_U, OPR_C_NPC
    } opr_c_sel_t;

    // Immediate routed to operand b
    typedef enum logic [1:0] {IMM_SEL_I, IMM_SEL_S, IMM_SEL_U, IMM_SEL_J} imm_b_sel_t;

    typedef struct packed {
        xlen_t imm_i;
        xlen_t imm_s;
        xlen_t imm_b;
        xlen_t imm_u;
        xlen_t imm_j;
    } imm_set_t;

    typedef struct packed {
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        opr_a_sel_t opr_a_sel;
        opr_b_sel_t opr_b_sel;
        opr_c_sel_t opr_c_sel;
        imm_b_sel_t imm_b_sel;
        alu_op_t    alu_op;
        lsu_op_t    lsu_op;
        cfu_op_t    cfu_op;
        logic       is_jal;     // Direct jump, raised from decode
    } dec_ctrl_t;

    typedef struct packed {
        xlen_t  pc;
        instr_u instr;
    } fetch_t;

    typedef struct packed {
        xlen_t                  pc;
        xlen_t                  opr_a;
        xlen_t                  opr_b;
        xlen_t                  opr_c;
        reg_addr_t              rd;
        alu_op_t                alu_op;
        lsu_op_t                lsu_op;
        cfu_op_t                cfu_op;
        logic [`RV_INSTR_W-1:0] instr;      // Raw word for trace
    } decode_uop_t;

endpackage

// File: rv_imm_gen.sv
// --------------------
// Purely combinational, no decode of the opcode
// All five immediates are formed every cycle
// --------------------
`timescale 1ns/1ps

module rv_imm_gen (
    input  rv_decode_pkg::instr_u   instr_i,
    output rv_decode_pkg::imm_set_t imm_o
);

    import rv_decode_pkg::*;

    // Signed source fields, extended by the cast to xlen_t
    always_comb begin
        imm_o.imm_i = xlen_t'($signed(instr_i.i.imm_11_0));

        imm_o.imm_s = xlen_t'($signed({instr_i.s.imm_11_5, instr_i.s.imm_4_0}));

        // Branch offset, bit 0 always clear
        imm_o.imm_b = xlen_t'($signed({instr_i.b.imm_12,
                                       instr_i.b.imm_11,
                                       instr_i.b.imm_10_5,
                                       instr_i.b.imm_4_1,
                                       1'b0}));

        imm_o.imm_u = xlen_t'($signed({instr_i.u.imm_31_12, 12'b0}));   // Upper 20 bits

        imm_o.imm_j = xlen_t'($signed({instr_i.j.imm_20,
                                       instr_i.j.imm_19_12,
                                       instr_i.j.imm_11,
                                       instr_i.j.imm_10_1,
                                       1'b0}));
    end

endmodule

// File: rv_uop_decode.sv
// --------------------
// RV32I base set only, combinational
// Unrecognised words give all-zero control, only rs1/rs2 follow the fields
// FENCE and SYSTEM opcodes fall into the unrecognised group
// --------------------
`timescale 1ns/1ps

module rv_uop_decode (
    input  rv_decode_pkg::instr_u    instr_i,
    output rv_decode_pkg::dec_ctrl_t ctrl_o
);

    import rv_decode_pkg::*;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    dec_ctrl_t  dec;
    logic       legal;
    logic       is_reg;     // OP rather than OP-IMM
    logic       alt_op;     // funct7 bit 5
    logic [2:0] f3;
    logic [6:0] f7;

    assign f3     = instr_i.r.funct3;
    assign f7     = instr_i.r.funct7;
    assign is_reg = instr_i.r.opcode == OPC_OP;
    assign alt_op = f7[5];

    always_comb begin
        dec   = '0;
        legal = 1'b1;
        case (instr_i.r.opcode)
            OPC_LUI: begin
                dec.rd        = instr_i.u.rd;
                dec.opr_b_sel = OPR_B_IMM;
                dec.imm_b_sel = IMM_SEL_U;
                dec.alu_op    = ALU_OP_OR;      // 0 | imm
            end
            OPC_AUIPC: begin
                dec.rd        = instr_i.u.rd;
                dec.opr_a_sel = OPR_A_PC;
                dec.opr_b_sel = OPR_B_IMM;
                dec.imm_b_sel = IMM_SEL_U;
                dec.opr_c_sel = OPR_C_IMM_U;
                dec.alu_op    = ALU_OP_ADD;
            end
            OPC_JAL: begin
                dec.rd        = instr_i.j.rd;
                dec.opr_a_sel = OPR_A_PC;
                dec.opr_b_sel = OPR_B_IMM;
                dec.imm_b_sel = IMM_SEL_J;
                dec.opr_c_sel = OPR_C_NPC;     // Link value
                dec.cfu_op    = CFU_OP_JAL;
                dec.is_jal    = 1'b1;
            end
            OPC_JALR: begin
                // Target needs rs1, so execute resolves it
                legal         = f3 == 3'b000;
                dec.rd        = instr_i.i.rd;
                dec.opr_a_sel = OPR_A_RS1;
                dec.opr_b_sel = OPR_B_IMM;
                dec.opr_c_sel = OPR_C_NPC;
                dec.cfu_op    = CFU_OP_JAL;
            end
            OPC_BRANCH: begin
                dec.opr_a_sel = OPR_A_RS1;
                dec.opr_b_sel = OPR_B_RS2;
                dec.opr_c_sel = OPR_C_IMM_B;
                dec.alu_op    = ALU_OP_SUB;     // Compare by subtraction
                case (f3)
                    3'b000:  dec.cfu_op = CFU_OP_BEQ;
                    3'b001:  dec.cfu_op = CFU_OP_BNE;
                    3'b100:  dec.cfu_op = CFU_OP_BLT;
                    3'b101:  dec.cfu_op = CFU_OP_BGE;
                    3'b110:  dec.cfu_op = CFU_OP_BLTU;
                    3'b111:  dec.cfu_op = CFU_OP_BGEU;
                    default: legal      = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                dec.rd        = instr_i.i.rd;
                dec.opr_a_sel = OPR_A_RS1;
                dec.opr_b_sel = OPR_B_IMM;
                dec.alu_op    = ALU_OP_ADD;
                case (f3)
                    3'b000:  dec.lsu_op = LSU_OP_LB;
                    3'b001:  dec.lsu_op = LSU_OP_LH;
                    3'b010:  dec.lsu_op = LSU_OP_LW;
                    3'b100:  dec.lsu_op = LSU_OP_LBU;
                    3'b101:  dec.lsu_op = LSU_OP_LHU;
                    default: legal      = 1'b0;
                endcase
            end
            OPC_STORE: begin
                dec.opr_a_sel = OPR_A_RS1;
                dec.opr_b_sel = OPR_B_IMM;
                dec.imm_b_sel = IMM_SEL_S;
                dec.opr_c_sel = OPR_C_RS2;     // Store data
                dec.alu_op    = ALU_OP_ADD;
                case (f3)
                    3'b000:  dec.lsu_op = LSU_OP_SB;
                    3'b001:  dec.lsu_op = LSU_OP_SH;
                    3'b010:  dec.lsu_op = LSU_OP_SW;
                    default: legal      = 1'b0;
                endcase
            end
            OPC_OP, OPC_OP_IMM: begin
                dec.rd        = instr_i.r.rd;
                dec.opr_a_sel = OPR_A_RS1;
                dec.opr_b_sel = is_reg ? OPR_B_RS2 : OPR_B_IMM;
                case (f3)
                    3'b000:  dec.alu_op = (is_reg && alt_op) ? ALU_OP_SUB : ALU_OP_ADD;
                    3'b001:  dec.alu_op = ALU_OP_SLL;
                    3'b010:  dec.alu_op = ALU_OP_SLT;
                    3'b011:  dec.alu_op = ALU_OP_SLTU;
                    3'b100:  dec.alu_op = ALU_OP_XOR;
                    3'b101:  dec.alu_op = alt_op ? ALU_OP_SRA : ALU_OP_SRL;
                    3'b110:  dec.alu_op = ALU_OP_OR;
                    default: dec.alu_op = ALU_OP_AND;
                endcase
                // funct7 only constrained where it is part of the encoding
                if (is_reg) begin
                    legal = (f7 == 7'b0) ||
                            (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
                end else if (f3 == 3'b001) begin
                    legal = f7 == 7'b0;
                end else if (f3 == 3'b101) begin
                    legal = f7 == 7'b0 || f7 == 7'b0100000;
                end
            end
            default: legal = 1'b0;
        endcase

        ctrl_o     = legal ? dec : '0;
        ctrl_o.rs1 = instr_i.r.rs1;     // Read ports see the raw fields
        ctrl_o.rs2 = instr_i.r.rs2;
    end

endmodule

// File: rv_decode_stage.sv
// --------------------
// Decode and operand gather, one pipeline register deep
// Register data is forwarded back in the same cycle as the addresses
// A JAL is held until the front end acknowledges its target
// --------------------
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module rv_decode_stage (
    input  logic                         g_clk,
    input  logic                         reset_i,
    input  logic                         s1_flush_i,
    input  logic                         s1_valid_i,
    input  rv_decode_pkg::fetch_t        s1_fetch_i,
    output logic                         s1_eat_o,
    output logic                         s1_cf_valid_o,
    input  logic                         s1_cf_ack_i,
    output rv_decode_pkg::xlen_t         s1_cf_target_o,
    output rv_decode_pkg::reg_addr_t     s1_rs1_addr_o,
    input  rv_decode_pkg::xlen_t         s1_rs1_data_i,
    output rv_decode_pkg::reg_addr_t     s1_rs2_addr_o,
    input  rv_decode_pkg::xlen_t         s1_rs2_data_i,
    output logic                         s2_valid_o,
    input  logic                         s2_ready_i,
    output rv_decode_pkg::decode_uop_t   s2_uop_o
);

    import rv_decode_pkg::*;

    imm_set_t    imm;
    dec_ctrl_t   ctrl;
    xlen_t       npc;
    xlen_t       opr_a;
    xlen_t       opr_b;
    xlen_t       opr_c;
    xlen_t       imm_b_opr;
    logic        cf_wait;
    decode_uop_t uop_d;

    rv_imm_gen u_imm_gen (
        .instr_i (s1_fetch_i.instr),
        .imm_o   (imm)
    );

    rv_uop_decode u_uop_decode (
        .instr_i (s1_fetch_i.instr),
        .ctrl_o  (ctrl)
    );

    assign s1_rs1_addr_o = ctrl.rs1;
    assign s1_rs2_addr_o = ctrl.rs2;

    assign npc = s1_fetch_i.pc + xlen_t'(`RV_ILEN_BYTES);

    // Operand selection
    // --------------------
    always_comb begin
        case (ctrl.imm_b_sel)
            IMM_SEL_S: imm_b_opr = imm.imm_s;
            IMM_SEL_U: imm_b_opr = imm.imm_u;
            IMM_SEL_J: imm_b_opr = imm.imm_j;
            default:   imm_b_opr = imm.imm_i;
        endcase

        case (ctrl.opr_a_sel)
            OPR_A_RS1: opr_a = s1_rs1_data_i;
            OPR_A_PC:  opr_a = s1_fetch_i.pc;
            default:   opr_a = '0;
        endcase

        case (ctrl.opr_b_sel)
            OPR_B_RS2: opr_b = s1_rs2_data_i;
            OPR_B_IMM: opr_b = imm_b_opr;
            default:   opr_b = '0;
        endcase

        case (ctrl.opr_c_sel)
            OPR_C_RS2:   opr_c = s1_rs2_data_i;
            OPR_C_IMM_B: opr_c = imm.imm_b;
            OPR_C_IMM_U: opr_c = imm.imm_u;
            OPR_C_NPC:   opr_c = npc;
            default:     opr_c = '0;
        endcase
    end

    // Direct jump and stall
    // --------------------
    assign s1_cf_valid_o  = s1_valid_i && ctrl.is_jal;
    assign s1_cf_target_o = s1_fetch_i.pc + imm.imm_j;
    assign cf_wait        = s1_cf_valid_o && !s1_cf_ack_i;   // Hold JAL until acked

    assign s1_eat_o = s1_valid_i && !cf_wait && s2_ready_i;

    always_comb begin
        uop_d.pc     = s1_fetch_i.pc;
        uop_d.opr_a  = opr_a;
        uop_d.opr_b  = opr_b;
        uop_d.opr_c  = opr_c;
        uop_d.rd     = ctrl.rd;
        uop_d.alu_op = ctrl.alu_op;
        uop_d.lsu_op = ctrl.lsu_op;
        uop_d.cfu_op = ctrl.cfu_op;
        uop_d.instr  = s1_fetch_i.instr;
    end

    // Decode to execute register
    // --------------------
    always_ff @(posedge g_clk) begin
        if (reset_i || s1_flush_i) begin
            s2_valid_o <= 1'b0;
            s2_uop_o   <= '0;
        end else if (s2_ready_i) begin
            s2_valid_o <= s1_eat_o;
            s2_uop_o   <= uop_d;
        end
    end

endmodule

// File: rv_decode_assert.sv
// --------------------
// Handshake properties of the decode stage
// Bound into rv_decode_stage, checked outside reset
// --------------------
`timescale 1ns/1ps

module rv_decode_assert (
    input logic                       g_clk,
    input logic                       reset_i,
    input logic                       s1_flush_i,
    input logic                       s1_valid_i,
    input logic                       s1_eat_i,
    input logic                       s1_cf_valid_i,
    input logic                       s1_cf_ack_i,
    input logic                       s2_valid_i,
    input logic                       s2_ready_i,
    input rv_decode_pkg::decode_uop_t s2_uop_i
);

    // A consumed instruction shows up on the execute side next cycle
    eat_loads_valid: assert property (@(posedge g_clk) disable iff (reset_i)
        (s1_eat_i && !s1_flush_i) |=> s2_valid_i)
        else $error("consumed instruction did not reach execute");

    idle_drains_valid: assert property (@(posedge g_clk) disable iff (reset_i)
        (s2_ready_i && !s1_valid_i) |=> !s2_valid_i)
        else $error("valid set with nothing fetched");

    // JAL waits for the front end
    jal_waits_for_ack: assert property (@(posedge g_clk) disable iff (reset_i)
        (s1_cf_valid_i && !s1_cf_ack_i && s2_ready_i) |=> !s2_valid_i)
        else $error("JAL issued before acknowledge");

    stall_holds_uop: assert property (@(posedge g_clk) disable iff (reset_i)
        (s2_valid_i && !s2_ready_i && !s1_flush_i) |=> (s2_valid_i && $stable(s2_uop_i)))
        else $error("execute side changed under back-pressure");

    flush_clears_valid: assert property (@(posedge g_clk) disable iff (reset_i)
        s1_flush_i |=> !s2_valid_i)
        else $error("valid still set after flush");

endmodule

// File: tb_clock_gen.sv
// --------------------
// 100 ns clock, reset high for the first 10 cycles
// Reset is released on a falling edge
// --------------------
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;     // Away from the sampling edge
    end

endmodule

// File: tb_decode.sv
// --------------------
// Random RV32I stream into the decode stage, compared against a reference decode
// Register data is address times an odd constant, returned in the same cycle
// Stops at the first mismatch
// --------------------
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module tb_decode;

    import rv_decode_pkg::*;

    localparam int N_INSTR        = 1500;
    localparam int TIMEOUT_CYCLES = 40 * N_INSTR + 10;

    logic        g_clk;
    logic        reset_i;
    logic        s1_flush_i;
    logic        s1_valid_i;
    fetch_t      s1_fetch_i;
    logic        s1_eat_o;
    logic        s1_cf_valid_o;
    logic        s1_cf_ack_i;
    xlen_t       s1_cf_target_o;
    reg_addr_t   s1_rs1_addr_o;
    xlen_t       s1_rs1_data_i;
    reg_addr_t   s1_rs2_addr_o;
    xlen_t       s1_rs2_data_i;
    logic        s2_valid_o;
    logic        s2_ready_i;
    decode_uop_t s2_uop_o;

    decode_uop_t pend_q[$];     // Uops consumed but not yet taken by execute
    int          cycles = 0;

    tb_clock_gen u_clock_gen (
        .clk_o (g_clk),
        .rst_o (reset_i)
    );

    rv_decode_stage UUT (
        .g_clk          (g_clk),
        .reset_i        (reset_i),
        .s1_flush_i     (s1_flush_i),
        .s1_valid_i     (s1_valid_i),
        .s1_fetch_i     (s1_fetch_i),
        .s1_eat_o       (s1_eat_o),
        .s1_cf_valid_o  (s1_cf_valid_o),
        .s1_cf_ack_i    (s1_cf_ack_i),
        .s1_cf_target_o (s1_cf_target_o),
        .s1_rs1_addr_o  (s1_rs1_addr_o),
        .s1_rs1_data_i  (s1_rs1_data_i),
        .s1_rs2_addr_o  (s1_rs2_addr_o),
        .s1_rs2_data_i  (s1_rs2_data_i),
        .s2_valid_o     (s2_valid_o),
        .s2_ready_i     (s2_ready_i),
        .s2_uop_o       (s2_uop_o)
    );

    bind rv_decode_stage rv_decode_assert u_assert (
        .g_clk         (g_clk),
        .reset_i       (reset_i),
        .s1_flush_i    (s1_flush_i),
        .s1_valid_i    (s1_valid_i),
        .s1_eat_i      (s1_eat_o),
        .s1_cf_valid_i (s1_cf_valid_o),
        .s1_cf_ack_i   (s1_cf_ack_i),
        .s2_valid_i    (s2_valid_o),
        .s2_ready_i    (s2_ready_i),
        .s2_uop_i      (s2_uop_o)
    );

    // Register file model
    // --------------------
    function automatic xlen_t reg_data(input reg_addr_t a);
        return xlen_t'(a) * 32'h9E37_79B1;
    endfunction

    assign s1_rs1_data_i = reg_data(s1_rs1_addr_o);
    assign s1_rs2_data_i = reg_data(s1_rs2_addr_o);

    // Reference decode, straight from the RV32I encoding
    // --------------------
    function automatic xlen_t imm_i(input logic [31:0] w);
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic xlen_t imm_s(input logic [31:0] w);
        return {{20{w[31]}}, w[31:25], w[11:7]};
    endfunction

    function automatic xlen_t imm_b(input logic [31:0] w);
        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic xlen_t imm_u(input logic [31:0] w);
        return {w[31:12], 12'b0};
    endfunction

    function automatic xlen_t imm_j(input logic [31:0] w);
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic is_direct_jump(input logic [31:0] w);
        return w[6:0] == 7'b1101111;
    endfunction

    function automatic alu_op_t alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic reg_op);
        case (f3)
            3'b000:  return (reg_op && alt) ? ALU_OP_SUB : ALU_OP_ADD;
            3'b001:  return ALU_OP_SLL;
            3'b010:  return ALU_OP_SLT;
            3'b011:  return ALU_OP_SLTU;
            3'b100:  return ALU_OP_XOR;
            3'b101:  return alt ? ALU_OP_SRA : ALU_OP_SRL;
            3'b110:  return ALU_OP_OR;
            default: return ALU_OP_AND;
        endcase
    endfunction

    function automatic decode_uop_t decode_ref(input fetch_t f);
        logic [31:0] w;
        logic [2:0]  f3;
        logic [6:0]  f7;
        xlen_t       rs1v;
        xlen_t       rs2v;
        xlen_t       npc;
        logic        legal;
        decode_uop_t u;
        w     = f.instr;
        f3    = w[14:12];
        f7    = w[31:25];
        rs1v  = reg_data(w[19:15]);
        rs2v  = reg_data(w[24:20]);
        npc   = f.pc + xlen_t'(`RV_ILEN_BYTES);
        legal = 1'b1;
        u     = '0;
        case (w[6:0])
            7'b0110111: begin     // LUI
                u.rd     = w[11:7];
                u.opr_b  = imm_u(w);
                u.alu_op = ALU_OP_OR;
            end
            7'b0010111: begin     // AUIPC
                u.rd     = w[11:7];
                u.opr_a  = f.pc;
                u.opr_b  = imm_u(w);
                u.opr_c  = imm_u(w);
                u.alu_op = ALU_OP_ADD;
            end
            7'b1101111: begin     // JAL
                u.rd     = w[11:7];
                u.opr_a  = f.pc;
                u.opr_b  = imm_j(w);
                u.opr_c  = npc;
                u.cfu_op = CFU_OP_JAL;
            end
            7'b1100111: begin     // JALR
                legal    = f3 == 3'b000;
                u.rd     = w[11:7];
                u.opr_a  = rs1v;
                u.opr_b  = imm_i(w);
                u.opr_c  = npc;
                u.cfu_op = CFU_OP_JAL;
            end
            7'b1100011: begin     // Branches
                u.opr_a  = rs1v;
                u.opr_b  = rs2v;
                u.opr_c  = imm_b(w);
                u.alu_op = ALU_OP_SUB;
                case (f3)
                    3'b000:  u.cfu_op = CFU_OP_BEQ;
                    3'b001:  u.cfu_op = CFU_OP_BNE;
                    3'b100:  u.cfu_op = CFU_OP_BLT;
                    3'b101:  u.cfu_op = CFU_OP_BGE;
                    3'b110:  u.cfu_op = CFU_OP_BLTU;
                    3'b111:  u.cfu_op = CFU_OP_BGEU;
                    default: legal    = 1'b0;
                endcase
            end
            7'b0000011: begin     // Loads
                u.rd     = w[11:7];
                u.opr_a  = rs1v;
                u.opr_b  = imm_i(w);
                u.alu_op = ALU_OP_ADD;
                case (f3)
                    3'b000:  u.lsu_op = LSU_OP_LB;
                    3'b001:  u.lsu_op = LSU_OP_LH;
                    3'b010:  u.lsu_op = LSU_OP_LW;
                    3'b100:  u.lsu_op = LSU_OP_LBU;
                    3'b101:  u.lsu_op = LSU_OP_LHU;
                    default: legal    = 1'b0;
                endcase
            end
            7'b0100011: begin     // Stores
                u.opr_a  = rs1v;
                u.opr_b  = imm_s(w);
                u.opr_c  = rs2v;
                u.alu_op = ALU_OP_ADD;
                case (f3)
                    3'b000:  u.lsu_op = LSU_OP_SB;
                    3'b001:  u.lsu_op = LSU_OP_SH;
                    3'b010:  u.lsu_op = LSU_OP_SW;
                    default: legal    = 1'b0;
                endcase
            end
            7'b0110011: begin     // OP
                legal    = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                u.rd     = w[11:7];
                u.opr_a  = rs1v;
                u.opr_b  = rs2v;
                u.alu_op = alu_ref(f3, f7[5], 1'b1);
            end
            7'b0010011: begin     // OP-IMM, shifts keep funct7 in the immediate
                if (f3 == 3'b001) begin
                    legal = f7 == 7'h00;
                end else if (f3 == 3'b101) begin
                    legal = (f7 == 7'h00) || (f7 == 7'h20);
                end
                u.rd     = w[11:7];
                u.opr_a  = rs1v;
                u.opr_b  = imm_i(w);
                u.alu_op = alu_ref(f3, f7[5], 1'b0);
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            u = '0;
        end
        u.pc    = f.pc;
        u.instr = w;
        return u;
    endfunction

    // Random instruction words
    // --------------------
    function automatic logic [31:0] rand_instr();
        logic [31:0] w;
        logic [2:0]  f3;
        w = $urandom;
        if ($urandom_range(99) < 5) begin
            case ($urandom_range(3))
                0:       w[6:0]   = 7'b0001111;     // FENCE
                1:       w        = 32'h0000_0073;  // ECALL
                2:       w[6:0]   = 7'b1111111;
                default: begin
                    w[6:0]   = 7'b0110011;          // M extension, dropped
                    w[31:25] = 7'b0000001;
                end
            endcase
            return w;
        end
        f3 = w[14:12];
        case ($urandom_range(8))
            0: w[6:0] = 7'b0110111;
            1: w[6:0] = 7'b0010111;
            2: w[6:0] = 7'b1101111;
            3: begin
                w[6:0]   = 7'b1100111;
                w[14:12] = 3'b000;
            end
            4: begin
                w[6:0] = 7'b1100011;
                if (f3[2:1] == 2'b01) begin
                    w[14] = 1'b1;
                end
            end
            5: begin
                w[6:0] = 7'b0000011;
                if (f3 == 3'b011 || f3[2:1] == 2'b11) begin
                    w[14:12] = 3'b010;
                end
            end
            6: begin
                w[6:0]   = 7'b0100011;
                w[14:12] = 3'($urandom_range(2));
            end
            7: begin
                w[6:0]   = 7'b0110011;
                w[31:25] = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1) == 1)
                           ? 7'h20 : 7'h00;
            end
            default: begin
                w[6:0] = 7'b0010011;
                if (f3 == 3'b001) begin
                    w[31:25] = 7'h00;
                end else if (f3 == 3'b101) begin
                    w[31:25] = ($urandom_range(1) == 1) ? 7'h20 : 7'h00;
                end
            end
        endcase
        return w;
    endfunction

    // Compare tasks
    // --------------------
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_uop(input string name, input decode_uop_t got, input decode_uop_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                    $time, name, got, exp));
        end
    endtask

    // Scoreboard, inputs are stable at the rising edge
    // --------------------
    always @(posedge g_clk) begin
        logic jal_wait;
        jal_wait = is_direct_jump(s1_fetch_i.instr) && !s1_cf_ack_i;
        if (!reset_i) begin
            if (s1_valid_i) begin
                check_addr("s1_rs1_addr_o", s1_rs1_addr_o, s1_fetch_i.instr[19:15]);
                check_addr("s1_rs2_addr_o", s1_rs2_addr_o, s1_fetch_i.instr[24:20]);
            end
            check_bit("s1_cf_valid_o", s1_cf_valid_o,
                      s1_valid_i && is_direct_jump(s1_fetch_i.instr));
            if (s1_cf_valid_o) begin
                check_xlen("s1_cf_target_o", s1_cf_target_o,
                           s1_fetch_i.pc + imm_j(s1_fetch_i.instr));
            end
            check_bit("s1_eat_o", s1_eat_o, s1_valid_i && !jal_wait && s2_ready_i);

            check_bit("s2_valid_o", s2_valid_o, pend_q.size() != 0);
            if (s2_valid_o && pend_q.size() != 0) begin
                check_uop("s2_uop_o", s2_uop_o, pend_q[0]);
                if (s2_ready_i) begin
                    pend_q.delete(0);     // Taken by execute
                end
            end

            if (s1_flush_i) begin
                pend_q.delete();
            end else if (s1_eat_o) begin
                pend_q.push_back(decode_ref(s1_fetch_i));
            end
        end
    end

    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout after %0d cycles, stream did not drain",
                                    cycles));
        end
    end

    // Stimulus, driven on the falling edge
    // --------------------
    initial begin
        int          eaten;
        logic        held;
        void'($urandom(59));
        eaten       = 0;
        s1_flush_i  = 1'b0;
        s1_valid_i  = 1'b0;
        s1_fetch_i  = '0;
        s1_cf_ack_i = 1'b0;
        s2_ready_i  = 1'b0;

        repeat (2) @(negedge g_clk);
        wait (reset_i == 1'b0);
        check_bit("s2_valid_o", s2_valid_o, 1'b0);
        check_uop("s2_uop_o", s2_uop_o, '0);

        while (eaten < N_INSTR) begin
            @(negedge g_clk);
            if (s1_valid_i && s1_eat_o) begin
                eaten++;
            end
            held = s1_valid_i && !s1_eat_o;     // Fetch keeps it until consumed
            if (!held) begin
                s1_valid_i       = $urandom_range(99) < 80;
                s1_fetch_i.pc    = $urandom & 32'hFFFF_FFFC;
                s1_fetch_i.instr = rand_instr();
            end
            s2_ready_i  = $urandom_range(99) < 75;
            s1_cf_ack_i = $urandom_range(99) < 50;
            s1_flush_i  = $urandom_range(199) == 0;
        end

        @(negedge g_clk);
        s1_valid_i = 1'b0;
        s1_flush_i = 1'b0;
        s2_ready_i = 1'b1;
        while (pend_q.size() != 0) begin
            @(negedge g_clk);
        end
        @(negedge g_clk);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: list.f
+incdir+.
rv_decode_pkg.sv
rv_imm_gen.sv
rv_uop_decode.sv
rv_decode_stage.sv
rv_decode_assert.sv
tb_clock_gen.sv
tb_decode.sv

// File: run.sh
#!/bin/sh
# Builds and runs the decode stage testbench with Verilator
# Exit status is the simulator's own status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_decode -f list.f -o tb_decode
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_decode
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished cleanly"
exit 0
